// ==== build.f ====
logic/support_pkg.sv
logic/obi_phase_monitor.sv
logic/req_attribute_fifo.sv
logic/gntpar_error_tracker.sv
logic/core_event_tracker.sv
logic/support_logic.sv
tests/support_logic_checks.sv
tests/support_logic_tb.sv

// ==== Bender.yml ====
package:
  name: support_logic

sources:
  # design, package first
  - logic/support_pkg.sv
  - logic/obi_phase_monitor.sv
  - logic/req_attribute_fifo.sv
  - logic/gntpar_error_tracker.sv
  - logic/core_event_tracker.sv
  - logic/support_logic.sv
  # testbench
  - target: test
    files:
      - tests/support_logic_checks.sv
      - tests/support_logic_tb.sv

// ==== tests/support_logic_tb.sv ====
// testbench top with clock, reset, random OBI slaves and core stimulus for the support logic
module support_logic_tb;

  localparam int MAX_OUT       = support_pkg::DEF_MAX_OUTSTANDING;
  localparam int RUN_CYCLES    = 3000;
  localparam int DRAIN_TIMEOUT = 500;

  logic                      in_support_if;
  logic                      reset_i;
  support_pkg::obi_bus_t     instr_bus;
  support_pkg::obi_bus_t     data_bus;
  logic                      req_is_store;
  logic                      req_data_integrity;
  logic                      req_instr_integrity;
  logic                      fetch_enable;
  support_pkg::ctrl_fsm_t    ctrl;
  support_pkg::retire_t      retire;
  support_pkg::bus_status_t  instr_status;
  support_pkg::bus_status_t  data_status;
  support_pkg::instr_attr_t  instr_resp_attr;
  support_pkg::data_attr_t   data_resp_attr;
  support_pkg::core_events_t events;
  logic                      check_err;
  logic [3:0]                reached;

  int   seed;
  // slave side count of granted, unanswered requests
  int   instr_out;
  int   data_out;
  // new requests allowed until the drain phase
  logic issue;
  // debug mode of the generated retirements
  logic dbg_state;

  support_logic #(
    .MAX_OUTSTANDING (MAX_OUT),
    .CNT_W           (support_pkg::DEF_CNT_W)
  ) DUT (
    .in_support_if         (in_support_if),
    .reset_i               (reset_i),
    .instr_bus_i           (instr_bus),
    .data_bus_i            (data_bus),
    .req_is_store_i        (req_is_store),
    .req_data_integrity_i  (req_data_integrity),
    .req_instr_integrity_i (req_instr_integrity),
    .fetch_enable_i        (fetch_enable),
    .ctrl_i                (ctrl),
    .retire_i              (retire),
    .instr_status_o        (instr_status),
    .data_status_o         (data_status),
    .instr_resp_attr_o     (instr_resp_attr),
    .data_resp_attr_o      (data_resp_attr),
    .events_o              (events)
  );

  support_logic_checks checks (
    .in_support_if         (in_support_if),
    .reset_i               (reset_i),
    .instr_bus_i           (instr_bus),
    .data_bus_i            (data_bus),
    .req_is_store_i        (req_is_store),
    .req_data_integrity_i  (req_data_integrity),
    .req_instr_integrity_i (req_instr_integrity),
    .fetch_enable_i        (fetch_enable),
    .ctrl_i                (ctrl),
    .retire_i              (retire),
    .instr_status_i        (instr_status),
    .data_status_i         (data_status),
    .instr_resp_attr_i     (instr_resp_attr),
    .data_resp_attr_i      (data_resp_attr),
    .events_i              (events),
    .err_o                 (check_err),
    .reached_o             (reached)
  );

  initial begin
    in_support_if = 1'b0;
    forever #2 in_support_if = ~in_support_if;
  end

  always @(posedge check_err) begin
    $display("TB FAILED");
    $fatal(1, "check failure");
  end

  // ----------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // next cycle of the behavioral slave and requester for one bus
  task automatic next_obi(input support_pkg::obi_bus_t cur, inout int out_cnt,
                          output support_pkg::obi_bus_t nxt);
    out_cnt = out_cnt + int'(cur.req && cur.gnt) - int'(cur.rvalid);
    // a stalled request holds until granted
    nxt.req    = (cur.req && !cur.gnt) || (issue && (rand_below(2) == 0));
    nxt.gnt    = nxt.req && (out_cnt < MAX_OUT) && (rand_below(3) != 0);
    // occasional faulty parity
    nxt.gntpar = (rand_below(8) == 0) ? nxt.gnt : !nxt.gnt;
    // in-order answers no earlier than one cycle after the grant
    nxt.rvalid = (out_cnt > 0) && (rand_below(2) == 0);
  endtask

  task drive_cycle();
    support_pkg::obi_bus_t nxt_i;
    support_pkg::obi_bus_t nxt_d;
    support_pkg::ctrl_fsm_t ctrl_n;
    support_pkg::retire_t ret_n;
    next_obi(instr_bus, instr_out, nxt_i);
    next_obi(data_bus, data_out, nxt_d);
    if (rand_below(12) == 0) begin
      dbg_state = !dbg_state;
    end
    ctrl_n.pc_set  = (rand_below(6) == 0);
    ctrl_n.pc_mux  = support_pkg::pc_mux_e'(3'(rand_below(6)));
    ret_n.valid    = (rand_below(3) == 0);
    ret_n.dbg_mode = dbg_state;
    ret_n.is_dret  = dbg_state && (rand_below(4) == 0);
    ret_n.trap     = (rand_below(8) == 0);
    instr_bus           <= nxt_i;
    data_bus            <= nxt_d;
    req_is_store        <= 1'(rand_below(2));
    req_data_integrity  <= 1'(rand_below(2));
    req_instr_integrity <= 1'(rand_below(2));
    ctrl                <= ctrl_n;
    retire              <= ret_n;
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------

  initial begin : main_seq
    int waited;
    seed                = 83;
    reset_i             = 1'b1;
    instr_bus           = '{req: 1'b0, gnt: 1'b0, rvalid: 1'b0, gntpar: 1'b1};
    data_bus            = '{req: 1'b0, gnt: 1'b0, rvalid: 1'b0, gntpar: 1'b1};
    req_is_store        = 1'b0;
    req_data_integrity  = 1'b0;
    req_instr_integrity = 1'b0;
    fetch_enable        = 1'b0;
    ctrl                = '0;
    retire              = '0;
    instr_out           = 0;
    data_out            = 0;
    issue               = 1'b1;
    dbg_state           = 1'b0;
    repeat (8) @(posedge in_support_if);
    reset_i <= 1'b0;
    for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
      drive_cycle();
      // fetch enable rises once, drops for a while and returns
      fetch_enable <= (cyc >= 6) && !((cyc >= 400) && (cyc < 420));
      @(posedge in_support_if);
    end
    // drain both buses
    issue  = 1'b0;
    waited = 0;
    while ((instr_out != 0 || data_out != 0 || instr_bus.req || data_bus.req ||
            instr_bus.rvalid || data_bus.rvalid) && (waited < DRAIN_TIMEOUT)) begin
      drive_cycle();
      @(posedge in_support_if);
      waited++;
    end
    if (waited >= DRAIN_TIMEOUT) begin
      $display("timeout: outstanding OBI transactions did not drain");
      $display("TB FAILED");
      $fatal(1, "drain timeout");
    end
    repeat (2) @(posedge in_support_if);
    if (reached != 4'b1111) begin
      $display("stimulus missed a checked event, reached mask %b", reached);
      $display("TB FAILED");
      $fatal(1, "run failed");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// ==== tests/support_logic_checks.sv ====
// testbench checker: reference models of the OBI and core event rules with immediate assertions
module support_logic_checks (
  input  logic                      in_support_if,
  input  logic                      reset_i,
  input  support_pkg::obi_bus_t     instr_bus_i,
  input  support_pkg::obi_bus_t     data_bus_i,
  input  logic                      req_is_store_i,
  input  logic                      req_data_integrity_i,
  input  logic                      req_instr_integrity_i,
  input  logic                      fetch_enable_i,
  input  support_pkg::ctrl_fsm_t    ctrl_i,
  input  support_pkg::retire_t      retire_i,
  input  support_pkg::bus_status_t  instr_status_i,
  input  support_pkg::bus_status_t  data_status_i,
  input  support_pkg::instr_attr_t  instr_resp_attr_i,
  input  support_pkg::data_attr_t   data_resp_attr_i,
  input  support_pkg::core_events_t events_i,
  output logic                      err_o,
  output logic [3:0]                reached_o
);

  // ----------------------------------------------------------
  // model state, index 0 is the instruction bus, 1 the data bus
  // ----------------------------------------------------------

  // granted minus answered transactions
  int   cnt_m [2];
  // last cycle had req without gnt
  logic stall_m [2];
  // parity fault seen earlier in the open address phase
  logic bad_m [2];
  // parity fault of the request in this cycle's address phase
  logic perr_m [2];
  // attributes of granted requests, oldest first
  support_pkg::instr_attr_t instr_q [$];
  support_pkg::data_attr_t  data_q [$];
  // core event models
  logic win_m;
  logic gnt_prev_m;
  logic rae_m;
  logic in_dbg_m;
  logic dret_pend_m;
  logic fetch_seen_m;

  initial begin
    err_o     = 1'b0;
    reached_o = 4'b0000;
  end

  task report_mismatch(input string name, input int expected, input int actual);
    // only the first error is shown
    if (!err_o) begin
      $display("ERR %s expected %0h actual %0h", name, expected, actual);
    end
    err_o = 1'b1;
  endtask

  task report_failure(input string msg);
    if (!err_o) begin
      $display("%s", msg);
    end
    err_o = 1'b1;
  endtask

  // one OBI cycle of phase and parity bookkeeping
  task update_bus(input int idx, input support_pkg::obi_bus_t b);
    perr_m[idx]  = b.req && (bad_m[idx] || (b.gnt == b.gntpar));
    bad_m[idx]   = b.req && !b.gnt && perr_m[idx];
    stall_m[idx] = b.req && !b.gnt;
    cnt_m[idx]   = cnt_m[idx] + int'(b.req && b.gnt) - int'(b.rvalid);
  endtask

  task check_bus(input string name, input support_pkg::obi_bus_t b,
                 input support_pkg::bus_status_t st, input int idx);
    assert (st.v_addr_ph_cnt == cnt_m[idx])
      else report_mismatch({name, "_count"}, cnt_m[idx], st.v_addr_ph_cnt);
    assert (st.addr_ph_cont == stall_m[idx])
      else report_mismatch({name, "_addr_ph_cont"}, stall_m[idx], st.addr_ph_cont);
    assert (st.resp_ph_cont == ((cnt_m[idx] != 0) && !b.rvalid))
      else report_mismatch({name, "_resp_ph_cont"}, (cnt_m[idx] != 0) && !b.rvalid,
                           st.resp_ph_cont);
  endtask

  // ----------------------------------------------------------
  // model update on the clock edge
  // ----------------------------------------------------------

  always @(posedge in_support_if) begin : model_update
    logic trap_now;
    logic late_req;
    if (reset_i) begin
      for (int i = 0; i < 2; i++) begin
        cnt_m[i]   = 0;
        stall_m[i] = 1'b0;
        bad_m[i]   = 1'b0;
        perr_m[i]  = 1'b0;
      end
      instr_q.delete();
      data_q.delete();
      win_m        = 1'b0;
      gnt_prev_m   = 1'b0;
      rae_m        = 1'b0;
      in_dbg_m     = 1'b0;
      dret_pend_m  = 1'b0;
      fetch_seen_m = 1'b0;
    end else begin
      update_bus(0, instr_bus_i);
      update_bus(1, data_bus_i);
      // the head answers first, a grant of this cycle joins the tail
      if (instr_bus_i.rvalid && instr_q.size() > 0) begin
        void'(instr_q.pop_front());
      end
      if (instr_bus_i.req && instr_bus_i.gnt) begin
        instr_q.push_back({req_instr_integrity_i, perr_m[0]});
      end
      if (data_bus_i.rvalid && data_q.size() > 0) begin
        void'(data_q.pop_front());
      end
      if (data_bus_i.req && data_bus_i.gnt) begin
        data_q.push_back({req_is_store_i, req_data_integrity_i, perr_m[1]});
      end
      // exception window, trap before retirement
      trap_now = ctrl_i.pc_set && ((ctrl_i.pc_mux == support_pkg::PC_TRAP_EXC) ||
                                   (ctrl_i.pc_mux == support_pkg::PC_TRAP_DBE));
      late_req = data_bus_i.req && gnt_prev_m;
      if (trap_now) begin
        win_m = 1'b1;
        rae_m = rae_m || late_req;
      end else if (retire_i.valid) begin
        win_m = 1'b0;
        rae_m = 1'b0;
      end else if (win_m && late_req) begin
        rae_m = 1'b1;
      end
      gnt_prev_m = data_bus_i.req && data_bus_i.gnt;
      // debug mode follows retirements, a clean dret clears it a cycle later
      if (retire_i.valid) begin
        in_dbg_m = retire_i.dbg_mode;
      end
      if (dret_pend_m) begin
        in_dbg_m = 1'b0;
      end
      dret_pend_m = retire_i.valid && retire_i.is_dret && !retire_i.trap;
      fetch_seen_m = fetch_seen_m || fetch_enable_i;
    end
  end

  // ----------------------------------------------------------
  // checks mid-cycle, where all inputs and outputs are settled
  // ----------------------------------------------------------

  always @(negedge in_support_if) begin : port_checks
    logic exp_dbg;
    logic exp_fetch;
    if (!reset_i) begin
      check_bus("instr", instr_bus_i, instr_status_i, 0);
      check_bus("data", data_bus_i, data_status_i, 1);
      if (instr_bus_i.rvalid && instr_q.size() == 0) begin
        report_failure("instruction response arrived with no granted request");
      end else if (instr_bus_i.rvalid) begin
        assert (instr_resp_attr_i.had_integrity == instr_q[0].had_integrity)
          else report_mismatch("instr_integrity", instr_q[0].had_integrity,
                               instr_resp_attr_i.had_integrity);
        assert (instr_resp_attr_i.gntpar_err == instr_q[0].gntpar_err)
          else report_mismatch("instr_gntpar", instr_q[0].gntpar_err,
                               instr_resp_attr_i.gntpar_err);
      end else begin
        assert (instr_resp_attr_i == '0)
          else report_mismatch("instr_attr_idle", 0, instr_resp_attr_i);
      end
      if (data_bus_i.rvalid && data_q.size() == 0) begin
        report_failure("data response arrived with no granted request");
      end else if (data_bus_i.rvalid) begin
        assert (data_resp_attr_i[2:1] == {data_q[0].is_store, data_q[0].had_integrity})
          else report_mismatch("data_store_integrity",
                               {data_q[0].is_store, data_q[0].had_integrity},
                               data_resp_attr_i[2:1]);
        assert (data_resp_attr_i.gntpar_err == data_q[0].gntpar_err)
          else report_mismatch("data_gntpar", data_q[0].gntpar_err,
                               data_resp_attr_i.gntpar_err);
        reached_o[3] = reached_o[3] || data_resp_attr_i.gntpar_err;
      end else begin
        assert (data_resp_attr_i == '0)
          else report_mismatch("data_attr_idle", 0, data_resp_attr_i);
      end
      exp_dbg   = retire_i.valid && retire_i.dbg_mode && !in_dbg_m;
      exp_fetch = fetch_enable_i && !fetch_seen_m;
      assert (events_i.req_after_exception == rae_m)
        else report_mismatch("req_after_exception", rae_m, events_i.req_after_exception);
      assert (events_i.first_debug_ins == exp_dbg)
        else report_mismatch("first_debug_ins", exp_dbg, events_i.first_debug_ins);
      assert (events_i.first_fetch == exp_fetch)
        else report_mismatch("first_fetch", exp_fetch, events_i.first_fetch);
      // which events the stimulus has produced so far
      reached_o[0] = reached_o[0] || rae_m;
      reached_o[1] = reached_o[1] || exp_dbg;
      reached_o[2] = reached_o[2] || exp_fetch;
    end
  end

endmodule

// ==== logic/support_logic.sv ====
// support logic top: per-bus OBI monitors, attribute FIFOs and core event flags for checkers
module support_logic #(
  parameter int MAX_OUTSTANDING = support_pkg::DEF_MAX_OUTSTANDING,
  parameter int CNT_W           = support_pkg::DEF_CNT_W
) (
  input  logic                       in_support_if,
  input  logic                       reset_i,
  input  support_pkg::obi_bus_t      instr_bus_i,
  input  support_pkg::obi_bus_t      data_bus_i,
  input  logic                       req_is_store_i,
  input  logic                       req_data_integrity_i,
  input  logic                       req_instr_integrity_i,
  input  logic                       fetch_enable_i,
  input  support_pkg::ctrl_fsm_t     ctrl_i,
  input  support_pkg::retire_t       retire_i,
  output support_pkg::bus_status_t   instr_status_o,
  output support_pkg::bus_status_t   data_status_o,
  output support_pkg::instr_attr_t   instr_resp_attr_o,
  output support_pkg::data_attr_t    data_resp_attr_o,
  output support_pkg::core_events_t  events_o
);

  // ----------------------------------------------------------
  // local signals
  // ----------------------------------------------------------

  localparam int INSTR_ATTR_W = $bits(support_pkg::instr_attr_t);
  localparam int DATA_ATTR_W  = $bits(support_pkg::data_attr_t);

  // grant parity error of the request currently in its address phase
  logic                     instr_gntpar_err;
  logic                     data_gntpar_err;
  // attributes captured at grant time
  support_pkg::instr_attr_t instr_req_attr;
  support_pkg::data_attr_t  data_req_attr;

  assign instr_req_attr.had_integrity = req_instr_integrity_i;
  assign instr_req_attr.gntpar_err    = instr_gntpar_err;

  assign data_req_attr.is_store      = req_is_store_i;
  assign data_req_attr.had_integrity = req_data_integrity_i;
  assign data_req_attr.gntpar_err    = data_gntpar_err;

  // ----------------------------------------------------------
  // instruction bus
  // ----------------------------------------------------------

  obi_phase_monitor #(
    .CNT_W (CNT_W)
  ) u_instr_phase (
    .in_support_if (in_support_if),
    .reset_i       (reset_i),
    .bus_i         (instr_bus_i),
    .status_o      (instr_status_o)
  );

  gntpar_error_tracker u_instr_gntpar (
    .in_support_if (in_support_if),
    .reset_i       (reset_i),
    .bus_i         (instr_bus_i),
    .gntpar_err_o  (instr_gntpar_err)
  );

  req_attribute_fifo #(
    .ATTR_W          (INSTR_ATTR_W),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_instr_attr (
    .in_support_if (in_support_if),
    .reset_i       (reset_i),
    .bus_i         (instr_bus_i),
    .attr_i        (instr_req_attr),
    .resp_attr_o   (instr_resp_attr_o)
  );

  // ----------------------------------------------------------
  // data bus
  // ----------------------------------------------------------

  obi_phase_monitor #(
    .CNT_W (CNT_W)
  ) u_data_phase (
    .in_support_if (in_support_if),
    .reset_i       (reset_i),
    .bus_i         (data_bus_i),
    .status_o      (data_status_o)
  );

  gntpar_error_tracker u_data_gntpar (
    .in_support_if (in_support_if),
    .reset_i       (reset_i),
    .bus_i         (data_bus_i),
    .gntpar_err_o  (data_gntpar_err)
  );

  req_attribute_fifo #(
    .ATTR_W          (DATA_ATTR_W),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_data_attr (
    .in_support_if (in_support_if),
    .reset_i       (reset_i),
    .bus_i         (data_bus_i),
    .attr_i        (data_req_attr),
    .resp_attr_o   (data_resp_attr_o)
  );

  // ----------------------------------------------------------
  // core events
  // ----------------------------------------------------------

  // data bus feeds the request-after-exception detection
  core_event_tracker u_events (
    .in_support_if  (in_support_if),
    .reset_i        (reset_i),
    .ctrl_i         (ctrl_i),
    .retire_i       (retire_i),
    .data_bus_i     (data_bus_i),
    .fetch_enable_i (fetch_enable_i),
    .events_o       (events_o)
  );

endmodule

// ==== logic/core_event_tracker.sv ====
// core event tracker for request-after-exception, first debug and first fetch flags
module core_event_tracker (
  input  logic                       in_support_if,
  input  logic                       reset_i,
  input  support_pkg::ctrl_fsm_t     ctrl_i,
  input  support_pkg::retire_t       retire_i,
  input  support_pkg::obi_bus_t      data_bus_i,
  input  logic                       fetch_enable_i,
  output support_pkg::core_events_t  events_o
);

  // ----------------------------------------------------------
  // local signals
  // ----------------------------------------------------------

  // exception or debug entry trap taken this cycle
  logic trap_taken;
  // exception window open from a trap until the next retirement
  logic exc_window_q;
  // data address phase completed in the previous cycle
  logic data_gnt_q;
  logic req_after_exc_q;
  // set while retiring debug code
  logic dbg_flag_q;
  // a clean dret retired last cycle
  logic dret_pend_q;
  // fetch_enable_i has been seen since reset
  logic fetch_en_seen_q;
  // data request following a completed grant
  logic data_req_after_gnt;

  assign trap_taken = ctrl_i.pc_set &&
                      ((ctrl_i.pc_mux == support_pkg::PC_TRAP_EXC) ||
                       (ctrl_i.pc_mux == support_pkg::PC_TRAP_DBE));

  assign data_req_after_gnt = data_bus_i.req && data_gnt_q;

  // ----------------------------------------------------------
  // exception window
  // ----------------------------------------------------------

  // a trap takes priority over retirement and the open window keeps watching
  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      exc_window_q    <= 1'b0;
      data_gnt_q      <= 1'b0;
      req_after_exc_q <= 1'b0;
    end else begin
      data_gnt_q <= data_bus_i.req && data_bus_i.gnt;
      if (trap_taken) begin
        exc_window_q <= 1'b1;
        if (data_req_after_gnt) begin
          req_after_exc_q <= 1'b1;
        end
      end else if (retire_i.valid) begin
        exc_window_q    <= 1'b0;
        req_after_exc_q <= 1'b0;
      end else if (exc_window_q && data_req_after_gnt) begin
        req_after_exc_q <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // debug entry and start-up
  // ----------------------------------------------------------

  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      dbg_flag_q      <= 1'b0;
      dret_pend_q     <= 1'b0;
      fetch_en_seen_q <= 1'b0;
    end else begin
      if (retire_i.valid) begin
        dbg_flag_q <= retire_i.dbg_mode;
      end
      // one cycle after dret the next debug entry counts as first again
      if (dret_pend_q) begin
        dbg_flag_q <= 1'b0;
      end
      dret_pend_q <= retire_i.valid && retire_i.is_dret && !retire_i.trap;
      if (fetch_enable_i) begin
        fetch_en_seen_q <= 1'b1;
      end
    end
  end

  assign events_o.req_after_exception = req_after_exc_q;
  assign events_o.first_debug_ins     = retire_i.valid && retire_i.dbg_mode && !dbg_flag_q;
  assign events_o.first_fetch         = fetch_enable_i && !fetch_en_seen_q;

endmodule

// ==== logic/gntpar_error_tracker.sv ====
// grant parity tracker: marks a request whose address phase ever saw a gnt/gntpar mismatch
module gntpar_error_tracker (
  input  logic                  in_support_if,
  input  logic                  reset_i,
  input  support_pkg::obi_bus_t bus_i,
  output logic                  gntpar_err_o
);

  // ----------------------------------------------------------
  // local signals
  // ----------------------------------------------------------

  // gnt and gntpar must always be complementary
  logic par_bad;
  // error seen earlier in the same stalled address phase
  logic err_sticky_q;

  assign par_bad = (bus_i.gnt == bus_i.gntpar);

  // only meaningful while an address phase is open
  assign gntpar_err_o = bus_i.req && (par_bad || err_sticky_q);

  // ----------------------------------------------------------
  // sticky bit
  // ----------------------------------------------------------

  // held across ungranted cycles so the whole request is marked,
  // dropped once the phase ends or req goes away
  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      err_sticky_q <= 1'b0;
    end else if (bus_i.req && !bus_i.gnt) begin
      err_sticky_q <= gntpar_err_o;
    end else begin
      err_sticky_q <= 1'b0;
    end
  end

endmodule

// ==== logic/req_attribute_fifo.sv ====
// request attribute FIFO: holds each request's attributes from grant to its response
module req_attribute_fifo #(
  parameter int ATTR_W          = 1,
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic                  in_support_if,
  input  logic                  reset_i,
  input  support_pkg::obi_bus_t bus_i,
  input  logic [ATTR_W-1:0]     attr_i,
  output logic [ATTR_W-1:0]     resp_attr_o
);

  // ----------------------------------------------------------
  // storage and pointers
  // ----------------------------------------------------------

  // pointer width, at least one bit for a single entry FIFO
  localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(MAX_OUTSTANDING - 1);

  logic [ATTR_W-1:0] mem_q [MAX_OUTSTANDING];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  // push on every granted address phase, pop on every response
  logic              push;
  logic              pop;

  assign push = bus_i.req && bus_i.gnt;
  assign pop  = bus_i.rvalid;

  // ----------------------------------------------------------
  // pointer update
  // ----------------------------------------------------------

  // pointers wrap at the depth, which need not be a power of two
  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_IDX) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_IDX) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // payload write in the grant cycle
  always_ff @(posedge in_support_if) begin
    if (push) begin
      mem_q[wr_ptr_q] <= attr_i;
    end
  end

  // ----------------------------------------------------------
  // response side
  // ----------------------------------------------------------

  // responses come in grant order, so the head belongs to this rvalid
  // output stays zero between responses
  assign resp_attr_o = mem_q[rd_ptr_q] & {ATTR_W{pop}};

endmodule

// ==== logic/obi_phase_monitor.sv ====
// OBI phase monitor: address/response phase continuity and outstanding count for one bus
module obi_phase_monitor #(
  parameter int CNT_W = 3
) (
  input  logic                   in_support_if,
  input  logic                   reset_i,
  input  support_pkg::obi_bus_t  bus_i,
  output support_pkg::bus_status_t status_o
);

  // ----------------------------------------------------------
  // local signals
  // ----------------------------------------------------------

  // address phase completes on req and gnt together
  logic             addr_done;
  // req held without gnt, the phase carries into next cycle
  logic             addr_stall;
  logic             addr_ph_cont_q;
  // granted transactions still waiting for rvalid
  logic [CNT_W-1:0] cnt_q;

  assign addr_done  = bus_i.req && bus_i.gnt;
  assign addr_stall = bus_i.req && !bus_i.gnt;

  // ----------------------------------------------------------
  // registered phase state
  // ----------------------------------------------------------

  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      addr_ph_cont_q <= 1'b0;
      cnt_q          <= '0;
    end else begin
      addr_ph_cont_q <= addr_stall;
      // grant and response in one cycle leave the count unchanged
      case ({addr_done, bus_i.rvalid})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // ----------------------------------------------------------
  // status outputs
  // ----------------------------------------------------------

  assign status_o.addr_ph_cont  = addr_ph_cont_q;
  // waiting on a response that has not shown up this cycle
  assign status_o.resp_ph_cont  = (cnt_q != '0) && !bus_i.rvalid;
  assign status_o.v_addr_ph_cnt = cnt_q;

endmodule

// ==== logic/support_pkg.sv ====
// support logic package: shared bus, attribute and core event types plus defaults
package support_pkg;

  // ----------------------------------------------------------
  // default sizing
  // ----------------------------------------------------------

  // depth of each request attribute FIFO
  localparam int DEF_MAX_OUTSTANDING = 4;
  // outstanding counter width, must hold DEF_MAX_OUTSTANDING
  localparam int DEF_CNT_W = 3;

  // ----------------------------------------------------------
  // OBI bus view
  // ----------------------------------------------------------

  // one bus as the monitors see it, gntpar is the inverted copy of gnt
  typedef struct packed {
    logic req;
    logic gnt;
    logic rvalid;
    logic gntpar;
  } obi_bus_t;

  // phase status reported to the property checkers
  typedef struct packed {
    logic                 addr_ph_cont;
    logic                 resp_ph_cont;
    logic [DEF_CNT_W-1:0] v_addr_ph_cnt;
  } bus_status_t;

  // request attributes carried from grant to response
  typedef struct packed {
    logic is_store;
    logic had_integrity;
    logic gntpar_err;
  } data_attr_t;

  typedef struct packed {
    logic had_integrity;
    logic gntpar_err;
  } instr_attr_t;

  // ----------------------------------------------------------
  // core control and retirement
  // ----------------------------------------------------------

  // pc source selected by the controller
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_TRAP_EXC = 3'd3,
    PC_TRAP_DBE = 3'd4,
    PC_DRET     = 3'd5
  } pc_mux_e;

  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
  } ctrl_fsm_t;

  // one retirement report from the core
  typedef struct packed {
    logic valid;
    logic dbg_mode;
    logic is_dret;
    logic trap;
  } retire_t;

  // event flags for the checkers
  typedef struct packed {
    logic req_after_exception;
    logic first_debug_ins;
    logic first_fetch;
  } core_events_t;

endpackage
